// ==== cla_macros.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Core logic analyzer sizes and widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef CLA_MACROS_SVH
`define CLA_MACROS_SVH

// Debug bus
`define CLA_SIGNAL_WIDTH 16

// Event sources
`define CLA_MATCH_SETS 2
`define CLA_COUNTERS 2
`define CLA_COUNTER_WIDTH 8

// Bits 0-1 match sets, bits 2-3 counter targets
`define CLA_EVENTS 4
`define CLA_EVENT_SEL_WIDTH 2

// Sequencer
`define CLA_NODES 4
`define CLA_NODE_WIDTH 2
`define CLA_EAPS_PER_NODE 2

// Snapshot path toward the trace sink
`define CLA_SNAP_DEPTH 4
`define CLA_SNAP_CREDITS 2

`endif

// ==== claPkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Core logic analyzer shared types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "cla_macros.svh"

package claPkg;

  // Actions fired by one EAP
  typedef struct packed {
    logic incCounter0;
    logic incCounter1;
    logic clearCounters;
    logic snapshot;
    logic interrupt;
    logic traceStart;
    logic traceStop;
  } claActions_t;

  typedef struct packed {
    logic                             enable;
    logic [`CLA_EVENT_SEL_WIDTH-1:0]  eventSelect;
    logic [`CLA_NODE_WIDTH-1:0]       nextNode;
    claActions_t                      actions;
  } claEap_t;

  typedef struct packed {
    logic [`CLA_SIGNAL_WIDTH-1:0] mask;
    logic [`CLA_SIGNAL_WIDTH-1:0] match;
  } claMatchSet_t;

  // EAP index is node * EAPs per node + EAP number
  typedef struct packed {
    logic                                                  enable;
    claMatchSet_t [`CLA_MATCH_SETS-1:0]                    matchSets;
    logic [`CLA_COUNTERS-1:0][`CLA_COUNTER_WIDTH-1:0]      counterTargets;
    claEap_t [`CLA_NODES*`CLA_EAPS_PER_NODE-1:0]           eaps;
  } claConfig_t;

  // One captured record toward the trace sink
  typedef struct packed {
    logic [`CLA_NODE_WIDTH-1:0]   node;
    logic [`CLA_SIGNAL_WIDTH-1:0] signals;
  } claSnapshot_t;

endpackage

// ==== claEventGen.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Analyzer event generation from mask/match
// sets and saturating counters
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "cla_macros.svh"

module claEventGen (
  input  logic                           gated_clock,
  input  logic                           reset_n,
  input  logic [`CLA_SIGNAL_WIDTH-1:0]   debugSignals,
  input  claPkg::claConfig_t             cfg,
  input  claPkg::claActions_t            counterControl,
  output logic [`CLA_EVENTS-1:0]         events,
  output logic [`CLA_SIGNAL_WIDTH-1:0]   signalsReg
);

  logic [`CLA_COUNTERS-1:0][`CLA_COUNTER_WIDTH-1:0] counters;
  logic [`CLA_COUNTERS-1:0]                         incCounter;

  // Input stage, loads every cycle
  always_ff @(posedge gated_clock) begin
    signalsReg <= debugSignals;
  end

  assign incCounter = {counterControl.incCounter1, counterControl.incCounter0};

  // Clear beats increment, count holds at all ones
  always_ff @(posedge gated_clock) begin
    if (!reset_n) begin
      counters <= '0;
    end else if (counterControl.clearCounters) begin
      counters <= '0;
    end else begin
      for (int c = 0; c < `CLA_COUNTERS; c++) begin
        if (incCounter[c] && (counters[c] != '1)) begin
          counters[c] <= counters[c] + 1'b1;
        end
      end
    end
  end

  always_comb begin
    // Only masked bits take part in the compare
    for (int m = 0; m < `CLA_MATCH_SETS; m++) begin
      events[m] = ((signalsReg ^ cfg.matchSets[m].match) & cfg.matchSets[m].mask) == '0;
    end
    // Target events sit above the match events
    for (int c = 0; c < `CLA_COUNTERS; c++) begin
      events[`CLA_MATCH_SETS + c] = (counters[c] == cfg.counterTargets[c]);
    end
  end

endmodule

// ==== claNodeSequencer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Analyzer node sequencer with EAP
// evaluation and action state
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "cla_macros.svh"

module claNodeSequencer (
  input  logic                           gated_clock,
  input  logic                           reset_n,
  input  claPkg::claConfig_t             cfg,
  input  logic [`CLA_EVENTS-1:0]         events,
  input  logic [`CLA_SIGNAL_WIDTH-1:0]   signalsReg,
  input  logic                           interruptClear,
  output claPkg::claActions_t            counterControl,
  output logic [`CLA_NODE_WIDTH-1:0]     currentNode,
  output logic                           debugInterrupt,
  output logic                           traceActive,
  output logic                           snapPush,
  output claPkg::claSnapshot_t           snapRecord
);

  logic                  fire;
  claPkg::claEap_t       firedEap;
  claPkg::claActions_t   actions;

  // Scan from the top so the lowest numbered EAP wins
  always_comb begin
    claPkg::claEap_t eap;
    fire = 1'b0;
    firedEap = '0;
    for (int e = `CLA_EAPS_PER_NODE - 1; e >= 0; e--) begin
      eap = cfg.eaps[currentNode * `CLA_EAPS_PER_NODE + e];
      if (cfg.enable && eap.enable && events[eap.eventSelect]) begin
        fire = 1'b1;
        firedEap = eap;
      end
    end
  end

  assign actions = fire ? firedEap.actions : '0;

  // Counters update on the same edge as the node change
  assign counterControl = actions;

  // Record carries the node before the transition
  assign snapPush = actions.snapshot;
  always_comb begin
    snapRecord.node = currentNode;
    snapRecord.signals = signalsReg;
  end

  always_ff @(posedge gated_clock) begin
    if (!reset_n) begin
      currentNode <= '0;
    end else if (fire) begin
      currentNode <= firedEap.nextNode;
    end
  end

  // Sticky interrupt, a new set wins over clear
  always_ff @(posedge gated_clock) begin
    if (!reset_n) begin
      debugInterrupt <= 1'b0;
    end else if (actions.interrupt) begin
      debugInterrupt <= 1'b1;
    end else if (interruptClear) begin
      debugInterrupt <= 1'b0;
    end
  end

  // Stop has priority over start
  always_ff @(posedge gated_clock) begin
    if (!reset_n) begin
      traceActive <= 1'b0;
    end else if (actions.traceStop) begin
      traceActive <= 1'b0;
    end else if (actions.traceStart) begin
      traceActive <= 1'b1;
    end
  end

endmodule

// ==== claSnapshotQueue.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Snapshot FIFO with credit-counted
// sender toward the trace sink
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "cla_macros.svh"

module claSnapshotQueue (
  input  logic                   gated_clock,
  input  logic                   reset_n,
  input  logic                   snapPush,
  input  claPkg::claSnapshot_t   snapRecord,
  input  logic                   creditReturn,
  output logic                   snapValid,
  output claPkg::claSnapshot_t   snapData
);

  localparam int PtrWidth = $clog2(`CLA_SNAP_DEPTH);
  localparam int CreditWidth = $clog2(`CLA_SNAP_CREDITS + 1);

  claPkg::claSnapshot_t    entries [`CLA_SNAP_DEPTH];
  logic [PtrWidth-1:0]     wrPtr;
  logic [PtrWidth-1:0]     rdPtr;
  logic [PtrWidth:0]       fill;
  logic [CreditWidth-1:0]  credits;
  logic                    doWrite;
  logic                    doSend;

  // Full queue drops the push
  assign doWrite = snapPush && (fill != (PtrWidth + 1)'(`CLA_SNAP_DEPTH));
  assign doSend = (credits != '0) && (fill != '0);

  always_ff @(posedge gated_clock) begin
    if (doWrite) begin
      entries[wrPtr] <= snapRecord;
    end
    if (doSend) begin
      snapData <= entries[rdPtr];
    end
  end

  // Pointers wrap naturally, depth is a power of two
  always_ff @(posedge gated_clock) begin
    if (!reset_n) begin
      wrPtr <= '0;
      rdPtr <= '0;
      fill <= '0;
      snapValid <= 1'b0;
    end else begin
      if (doWrite) begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (doSend) begin
        rdPtr <= rdPtr + 1'b1;
      end
      fill <= fill + (PtrWidth + 1)'(doWrite) - (PtrWidth + 1)'(doSend);
      snapValid <= doSend;
    end
  end

  // One credit spent per send, one back per return pulse
  always_ff @(posedge gated_clock) begin
    if (!reset_n) begin
      credits <= CreditWidth'(`CLA_SNAP_CREDITS);
    end else begin
      credits <= credits - CreditWidth'(doSend) + CreditWidth'(creditReturn);
    end
  end

endmodule

// ==== claTop.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Core logic analyzer top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "cla_macros.svh"

module claTop (
  input  logic                           gated_clock,
  input  logic                           reset_n,
  input  logic [`CLA_SIGNAL_WIDTH-1:0]   debugSignals,
  input  claPkg::claConfig_t             cfg,
  input  logic                           interruptClear,
  input  logic                           creditReturn,
  output logic [`CLA_NODE_WIDTH-1:0]     currentNode,
  output logic                           debugInterrupt,
  output logic                           traceActive,
  output logic                           snapValid,
  output claPkg::claSnapshot_t           snapData
);

  logic [`CLA_EVENTS-1:0]        events;
  logic [`CLA_SIGNAL_WIDTH-1:0]  signalsReg;
  claPkg::claActions_t           counterControl;
  logic                          snapPush;
  claPkg::claSnapshot_t          snapRecord;

  claEventGen eventGen (
    .gated_clock    (gated_clock),
    .reset_n        (reset_n),
    .debugSignals   (debugSignals),
    .cfg            (cfg),
    .counterControl (counterControl),
    .events         (events),
    .signalsReg     (signalsReg)
  );

  claNodeSequencer nodeSequencer (
    .gated_clock    (gated_clock),
    .reset_n        (reset_n),
    .cfg            (cfg),
    .events         (events),
    .signalsReg     (signalsReg),
    .interruptClear (interruptClear),
    .counterControl (counterControl),
    .currentNode    (currentNode),
    .debugInterrupt (debugInterrupt),
    .traceActive    (traceActive),
    .snapPush       (snapPush),
    .snapRecord     (snapRecord)
  );

  // Output path toward the trace sink
  claSnapshotQueue snapshotQueue (
    .gated_clock  (gated_clock),
    .reset_n      (reset_n),
    .snapPush     (snapPush),
    .snapRecord   (snapRecord),
    .creditReturn (creditReturn),
    .snapValid    (snapValid),
    .snapData     (snapData)
  );

endmodule

// ==== cla_checker.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bound checks on credits and reset state
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "cla_macros.svh"

module claChecker #(
  parameter int WatchedWidth = 1
) (
  input logic                    gated_clock,
  input logic                    reset_n,
  input logic [7:0]              credits,
  input logic                    sent,
  input logic [WatchedWidth-1:0] watched
);

  creditsBounded: assert property (@(posedge gated_clock) disable iff (!reset_n)
    credits <= `CLA_SNAP_CREDITS)
    else $error("credit count above the sink limit");

  // A send on the previous edge needed a credit
  sendNeedsCredit: assert property (@(posedge gated_clock) disable iff (!reset_n)
    sent |-> $past(credits) != 0)
    else $error("snapshot sent with no credit");

  resetClearsOutputs: assert property (@(posedge gated_clock)
    !reset_n |=> watched == '0)
    else $error("outputs not low after a reset cycle");

endmodule

bind claSnapshotQueue claChecker #(.WatchedWidth(1)) queueChecker (
  .gated_clock (gated_clock),
  .reset_n     (reset_n),
  .credits     (8'(credits)),
  .sent        (snapValid),
  .watched     (snapValid)
);

bind claTop claChecker #(.WatchedWidth(4)) topChecker (
  .gated_clock (gated_clock),
  .reset_n     (reset_n),
  .credits     (8'(snapshotQueue.credits)),
  .sent        (snapValid),
  .watched     ({currentNode, debugInterrupt, traceActive})
);

// ==== claTb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Core logic analyzer testbench with
// reference model and snapshot scoreboard
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "cla_macros.svh"

module claTb;

  localparam int TestCycles = 270;
  localparam int MarginCycles = 100;
  localparam logic [6:0] ActInc0 = 7'b1000000;
  localparam logic [6:0] ActInc1 = 7'b0100000;
  localparam logic [6:0] ActClear = 7'b0010000;
  localparam logic [6:0] ActSnap = 7'b0001000;
  localparam logic [6:0] ActIntr = 7'b0000100;
  localparam logic [6:0] ActStart = 7'b0000010;
  localparam logic [6:0] ActStop = 7'b0000001;

  typedef struct packed {
    logic [1:0]           node;
    logic [7:0]           cnt0;
    logic [7:0]           cnt1;
    logic                 intr;
    logic                 trace;
    logic                 push;
    claPkg::claSnapshot_t rec;
  } modelState_t;

  logic                 gated_clock;
  logic                 reset_n;
  logic [15:0]          debugSignals;
  claPkg::claConfig_t   cfg;
  logic                 interruptClear;
  logic                 creditReturn;
  logic [1:0]           currentNode;
  logic                 debugInterrupt;
  logic                 traceActive;
  logic                 snapValid;
  claPkg::claSnapshot_t snapData;

  integer               seed = 32'h094893e7;
  int                   valueErrors;
  int                   otherErrors;
  int                   received;
  int                   returned;
  int                   heldSends;
  int                   modelCredits;
  bit                   holdCredits;
  bit                   checking;
  bit                   doSend;
  bit                   doWrite;
  modelState_t          model;
  logic [15:0]          modelSig;
  logic                 expValid;
  claPkg::claSnapshot_t expData;
  claPkg::claSnapshot_t expQ[$];

  claTop UUT (
    .gated_clock    (gated_clock),
    .reset_n        (reset_n),
    .debugSignals   (debugSignals),
    .cfg            (cfg),
    .interruptClear (interruptClear),
    .creditReturn   (creditReturn),
    .currentNode    (currentNode),
    .debugInterrupt (debugInterrupt),
    .traceActive    (traceActive),
    .snapValid      (snapValid),
    .snapData       (snapData)
  );

  initial begin
    gated_clock = 1'b0;
    forever #2 gated_clock = ~gated_clock;
  end

  // Next model state for one clock edge
  function automatic modelState_t claStep(modelState_t s, claPkg::claConfig_t c,
                                          logic [15:0] sig, logic intClr);
    modelState_t n;
    logic [3:0] ev;
    claPkg::claEap_t eap;
    claPkg::claActions_t act;
    bit hit;
    n = s;
    n.rec.node = s.node;
    n.rec.signals = sig;
    act = '0;
    hit = 1'b0;
    for (int m = 0; m < 2; m++) begin
      ev[m] = (sig & c.matchSets[m].mask) == (c.matchSets[m].match & c.matchSets[m].mask);
    end
    ev[2] = s.cnt0 == c.counterTargets[0];
    ev[3] = s.cnt1 == c.counterTargets[1];
    for (int e = 0; e < 2; e++) begin
      eap = c.eaps[s.node * 2 + e];
      if (!hit && c.enable && eap.enable && ev[eap.eventSelect]) begin
        hit = 1'b1;
        act = eap.actions;
        n.node = eap.nextNode;
      end
    end
    if (act.clearCounters) begin
      n.cnt0 = '0;
      n.cnt1 = '0;
    end else begin
      if (act.incCounter0 && s.cnt0 != 8'hFF) n.cnt0 = s.cnt0 + 1'b1;
      if (act.incCounter1 && s.cnt1 != 8'hFF) n.cnt1 = s.cnt1 + 1'b1;
    end
    if (act.interrupt) n.intr = 1'b1;
    else if (intClr) n.intr = 1'b0;
    if (act.traceStop) n.trace = 1'b0;
    else if (act.traceStart) n.trace = 1'b1;
    n.push = act.snapshot;
    return n;
  endfunction

  function automatic claPkg::claEap_t eapOf(logic [1:0] sel, logic [1:0] next,
                                            logic [6:0] actBits);
    claPkg::claEap_t eap;
    eap.enable = 1'b1;
    eap.eventSelect = sel;
    eap.nextNode = next;
    eap.actions = claPkg::claActions_t'(actBits);
    return eap;
  endfunction

  task automatic reportValue(string name, logic [31:0] got, logic [31:0] exp);
    valueErrors++;
    $display("Fail %s: got %h, expected %h", name, got, exp);
  endtask

  task automatic applyReset;
    @(posedge gated_clock);
    #1;
    reset_n = 1'b0;
    repeat (8) @(posedge gated_clock);
    #1;
    reset_n = 1'b1;
    received = 0;
    returned = 0;
  endtask

  // Half the cycles carry the hit value
  task automatic runCycles(int n, logic [15:0] hitValue, bit randomClear);
    repeat (n) begin
      @(posedge gated_clock);
      #1;
      debugSignals = ($random(seed) & 1) ? hitValue : 16'($random(seed));
      interruptClear = randomClear ? 1'($random(seed)) : 1'b0;
    end
  endtask

  // Model and expected queue, same edge as the DUT
  always @(posedge gated_clock) begin
    if (!reset_n) begin
      model = '0;
      expQ.delete();
      modelCredits = `CLA_SNAP_CREDITS;
      expValid = 1'b0;
      checking = 1'b1;
    end else begin
      model = claStep(model, cfg, modelSig, interruptClear);
      doSend = modelCredits > 0 && expQ.size() > 0;
      doWrite = model.push && expQ.size() != `CLA_SNAP_DEPTH;
      expValid = doSend;
      if (doSend) expData = expQ.pop_front();
      if (doWrite) expQ.push_back(model.rec);
      modelCredits = modelCredits + int'(creditReturn) - int'(doSend);
    end
    modelSig = debugSignals;
  end

  always @(negedge gated_clock) begin
    if (checking) begin
      if (currentNode !== model.node) reportValue("currentNode", currentNode, model.node);
      if (debugInterrupt !== model.intr) reportValue("debugInterrupt", debugInterrupt, model.intr);
      if (traceActive !== model.trace) reportValue("traceActive", traceActive, model.trace);
      if (snapValid !== expValid) reportValue("snapValid", snapValid, expValid);
      if (snapValid === 1'b1) begin
        received++;
        if (holdCredits) heldSends++;
        if (expValid && snapData !== expData) reportValue("snapData", snapData, expData);
      end
    end
  end

  // Trace sink hands credits back after random delays
  always @(posedge gated_clock) begin
    #1;
    creditReturn = 1'b0;
    if (reset_n && !holdCredits && received > returned && ($random(seed) & 3) == 0) begin
      creditReturn = 1'b1;
      returned++;
    end
  end

  initial begin
    #((TestCycles + MarginCycles) * 4);
    $display("Timeout: the run did not finish within the expected number of cycles");
    $display("** FAIL **");
    $finish;
  end

  initial begin
    reset_n = 1'b0;
    debugSignals = '0;
    cfg = '0;
    interruptClear = 1'b0;
    creditReturn = 1'b0;
    holdCredits = 1'b0;
    checking = 1'b0;
    applyReset();
    // Enable low, nothing may move
    runCycles(20, 16'hFFFF, 1'b1);
    // Match walk 0 -> 1 -> 2 with EAP0 priority in node 0
    cfg.enable = 1'b1;
    cfg.matchSets[0].mask = 16'h00FF;
    cfg.matchSets[0].match = 16'h0012;
    cfg.matchSets[1].mask = 16'hFF00;
    cfg.matchSets[1].match = 16'h3400;
    cfg.eaps[0] = eapOf(2'd0, 2'd1, ActSnap);
    cfg.eaps[1] = eapOf(2'd1, 2'd3, ActSnap | ActIntr);
    cfg.eaps[2] = eapOf(2'd1, 2'd2, ActSnap);
    cfg.eaps[4] = eapOf(2'd0, 2'd0, ActSnap | ActStart);
    cfg.eaps[6] = eapOf(2'd0, 2'd0, ActStop);
    runCycles(20, 16'h3412, 1'b0);
    runCycles(20, 16'h0012, 1'b0);
    runCycles(20, 16'h3400, 1'b0);
    // Counter target moves the node, clear restarts it
    applyReset();
    cfg = '0;
    cfg.enable = 1'b1;
    cfg.counterTargets[0] = 8'd5;
    cfg.counterTargets[1] = 8'hC8;
    cfg.eaps[0] = eapOf(2'd2, 2'd1, ActSnap);
    cfg.eaps[1] = eapOf(2'd0, 2'd0, ActInc0);
    cfg.eaps[2] = eapOf(2'd0, 2'd0, ActClear | ActInc1);
    runCycles(40, 16'h0000, 1'b0);
    // Sticky interrupt and trace priorities
    applyReset();
    cfg = '0;
    cfg.enable = 1'b1;
    cfg.matchSets[1].mask = 16'hFFFF;
    cfg.matchSets[1].match = 16'hA5A5;
    cfg.eaps[0] = eapOf(2'd1, 2'd1, ActIntr | ActStart);
    cfg.eaps[2] = eapOf(2'd1, 2'd0, ActIntr | ActStart | ActStop);
    runCycles(60, 16'hA5A5, 1'b1);
    // Credits withheld, queue overflows
    applyReset();
    cfg = '0;
    cfg.enable = 1'b1;
    cfg.eaps[0] = eapOf(2'd0, 2'd0, ActSnap);
    holdCredits = 1'b1;
    heldSends = 0;
    runCycles(20, 16'h0000, 1'b0);
    holdCredits = 1'b0;
    cfg.enable = 1'b0;
    if (heldSends > `CLA_SNAP_CREDITS) begin
      otherErrors++;
      $display("More records were sent than credits allowed while credits were withheld");
    end
    while (expQ.size() != 0 || expValid || received != returned) begin
      @(posedge gated_clock);
    end
    repeat (4) @(posedge gated_clock);
    $display("Errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
    if (valueErrors + otherErrors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+.
claPkg.sv
claEventGen.sv
claNodeSequencer.sv
claSnapshotQueue.sv
claTop.sv
cla_checker.sv
claTb.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module claTb -o claSim || exit 1
out=$(./obj_dir/claSim)
echo "$out"
echo "$out" | grep -qF '** PASS **' && exit 0 || exit 1
